// ==== vram_pkg.sv ====
package vram_pkg;

  //////////////////////////////////////////////////
  // bus widths
  //////////////////////////////////////////////////

  // axi4-lite data bus, fixed at one 32-bit word
  localparam int data_width = 32;

  // one strobe bit per byte lane
  localparam int strb_width = data_width / 8;

  // byte offset bits below the word index
  // (a 32-bit word spans four byte addresses)
  localparam int addr_lsb = 2;

  //////////////////////////////////////////////////
  // vector types
  //////////////////////////////////////////////////

  // one vram word as seen on wdata / rdata
  typedef logic [data_width-1:0] axi_data_t;

  // byte-lane enables of a write
  typedef logic [strb_width-1:0] axi_strb_t;

  // bresp / rresp encoding
  typedef logic [1:0] axi_resp_t;

  // normal access complete, the only code this slave returns
  localparam axi_resp_t resp_okay = 2'b00;

  //////////////////////////////////////////////////
  // write response fsm
  //////////////////////////////////////////////////

  // idle    no write in progress
  // wait_1  first delay cycle after the memory write
  // wait_2  second delay cycle
  // wait_3  bvalid up, waiting for bready
  typedef enum logic [1:0] {
    idle,
    wait_1,
    wait_2,
    wait_3
  } wresp_state_t;

endpackage

// ==== vram_req_if.sv ====
interface vram_req_if #(
  parameter int vram_addr_bits = 14
);

  // single-cycle strobe, one per accepted axi transaction
  logic req_valid;
  // high for a write, low for a read
  logic req_write;
  // word index into the vram
  logic [vram_addr_bits-1:0] req_index;
  // write payload, ignored on reads
  vram_pkg::axi_data_t req_wdata;
  vram_pkg::axi_strb_t req_wstrb;

  // request stage side
  modport stage (
    output req_valid,
    output req_write,
    output req_index,
    output req_wdata,
    output req_wstrb
  );

  // ram side, always ready so no back-pressure
  modport bank (
    input req_valid,
    input req_write,
    input req_index,
    input req_wdata,
    input req_wstrb
  );

endinterface

// ==== axi_request_stage.sv ====
module axi_request_stage #(
  parameter int axi_addr_width = 16,
  parameter int vram_addr_bits = 14
) (
  input  logic                      s_axi_aclk,
  input  logic                      s_axi_aresetn,
  // write address channel
  input  logic [axi_addr_width-1:0] awaddr,
  input  logic                      awvalid,
  output logic                      awready,
  // write data channel
  input  vram_pkg::axi_data_t       wdata,
  input  vram_pkg::axi_strb_t       wstrb,
  input  logic                      wvalid,
  output logic                      wready,
  // read address channel
  input  logic [axi_addr_width-1:0] araddr,
  input  logic                      arvalid,
  output logic                      arready,
  // response handshake finished in the response stage
  input  logic                      txn_done,
  // request towards the ram
  vram_req_if.stage                 req
);

  // word index must cover the byte address above the lane offset
  if (vram_addr_bits + vram_pkg::addr_lsb != axi_addr_width)
  begin : g_width_check
    $error("axi_addr_width must equal vram_addr_bits plus addr_lsb");
  end

  // one transaction outstanding, from acceptance until txn_done
  logic busy;
  // acceptance conditions seen on this edge
  logic write_go;
  logic read_go;
  // word index cut out of each byte address
  logic [vram_addr_bits-1:0] aw_index;
  logic [vram_addr_bits-1:0] ar_index;

  assign aw_index = awaddr[vram_pkg::addr_lsb +: vram_addr_bits];
  assign ar_index = araddr[vram_pkg::addr_lsb +: vram_addr_bits];

  //////////////////////////////////////////////////
  // acceptance
  //////////////////////////////////////////////////

  // address and data are taken together, never one alone
  assign write_go = awvalid && wvalid && !busy;
  // write wins when both arrive on the same edge
  assign read_go = arvalid && !busy && !write_go;

  // ready pulses, busy flag and request strobe
  always_ff @(posedge s_axi_aclk)
  begin
    if (!s_axi_aresetn)
    begin
      busy          <= 1'b0;
      awready       <= 1'b0;
      wready        <= 1'b0;
      arready       <= 1'b0;
      req.req_valid <= 1'b0;
    end
    else
    begin
      // busy rises with the ready pulse, so ready lasts one cycle
      awready       <= write_go;
      wready        <= write_go;
      arready       <= read_go;
      req.req_valid <= write_go || read_go;
      if (write_go || read_go)
      begin
        busy <= 1'b1;
      end
      else if (txn_done)
      begin
        busy <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // request payload
  //////////////////////////////////////////////////

  // captured on the accepting edge, valid alongside req_valid
  always_ff @(posedge s_axi_aclk)
  begin
    if (write_go || read_go)
    begin
      req.req_write <= write_go;
      req.req_index <= write_go ? aw_index : ar_index;
      req.req_wdata <= wdata;
      req.req_wstrb <= wstrb;
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // write address and write data always handshake in the same cycle
  a_aw_w_paired: assert property (
    @(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    awready == wready
  ) else $error("awready and wready differ");

  // a ready only on the edge that starts a transaction, never while one is open
  a_no_ready_busy: assert property (
    @(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    (awready || arready) |-> $rose(busy)
  ) else $error("ready raised while a transaction is outstanding");

endmodule

// ==== vram_bank.sv ====
module vram_bank #(
  parameter int vram_addr_bits = 14
) (
  input  logic                s_axi_aclk,
  input  logic                s_axi_aresetn,
  // request from the request stage
  vram_req_if.bank            req,
  // read word, valid for one cycle
  output logic                rd_valid,
  output vram_pkg::axi_data_t rd_data,
  // memory write has landed
  output logic                wr_done
);

  localparam int depth = 2 ** vram_addr_bits;

  // text ram, one word per character cell pair
  vram_pkg::axi_data_t mem [depth];

  //////////////////////////////////////////////////
  // single shared port
  //////////////////////////////////////////////////

  // write merges only the strobed byte lanes, read is registered
  always_ff @(posedge s_axi_aclk)
  begin
    if (req.req_valid && req.req_write)
    begin
      for (int lane = 0; lane < vram_pkg::strb_width; lane++)
      begin
        if (req.req_wstrb[lane])
        begin
          mem[req.req_index][lane*8 +: 8] <= req.req_wdata[lane*8 +: 8];
        end
      end
    end
    else if (req.req_valid)
    begin
      rd_data <= mem[req.req_index];
    end
  end

  // completion pulses one cycle after the request
  always_ff @(posedge s_axi_aclk)
  begin
    if (!s_axi_aresetn)
    begin
      rd_valid <= 1'b0;
      wr_done  <= 1'b0;
    end
    else
    begin
      rd_valid <= req.req_valid && !req.req_write;
      wr_done  <= req.req_valid && req.req_write;
    end
  end

  // one request in flight, so a read and a write never finish together
  a_one_done: assert property (
    @(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    !(rd_valid && wr_done)
  ) else $error("rd_valid and wr_done high in the same cycle");

endmodule

// ==== axi_response_stage.sv ====
module axi_response_stage #(
  parameter int write_resp_delay = 3
) (
  input  logic                s_axi_aclk,
  input  logic                s_axi_aresetn,
  // completions from the ram
  input  logic                rd_valid,
  input  vram_pkg::axi_data_t rd_data,
  input  logic                wr_done,
  // write response channel
  output logic                bvalid,
  output vram_pkg::axi_resp_t bresp,
  input  logic                bready,
  // read data channel
  output logic                rvalid,
  output vram_pkg::axi_data_t rdata,
  output vram_pkg::axi_resp_t rresp,
  input  logic                rready,
  // back to the request stage
  output logic                txn_done
);

  // the fsm has two delay states ahead of the response state
  if (write_resp_delay < 1 || write_resp_delay > 3)
  begin : g_delay_check
    $error("write_resp_delay must be 1, 2 or 3");
  end

  vram_pkg::wresp_state_t wresp_state;
  vram_pkg::wresp_state_t wresp_next;

  //////////////////////////////////////////////////
  // write response
  //////////////////////////////////////////////////

  // entry state after wr_done picks how many delay cycles remain
  always_comb
  begin
    wresp_next = wresp_state;
    case (wresp_state)
      vram_pkg::idle:
      begin
        if (wr_done)
        begin
          if (write_resp_delay == 1)
            wresp_next = vram_pkg::wait_3;
          else if (write_resp_delay == 2)
            wresp_next = vram_pkg::wait_2;
          else
            wresp_next = vram_pkg::wait_1;
        end
      end
      vram_pkg::wait_1: wresp_next = vram_pkg::wait_2;
      vram_pkg::wait_2: wresp_next = vram_pkg::wait_3;
      // hold the response until the master takes it
      vram_pkg::wait_3:
      begin
        if (bready)
          wresp_next = vram_pkg::idle;
      end
      default: wresp_next = vram_pkg::idle;
    endcase
  end

  always_ff @(posedge s_axi_aclk)
  begin
    if (!s_axi_aresetn)
      wresp_state <= vram_pkg::idle;
    else
      wresp_state <= wresp_next;
  end

  // bvalid is decoded straight from the fsm register
  assign bvalid = (wresp_state == vram_pkg::wait_3);
  assign bresp  = vram_pkg::resp_okay;

  //////////////////////////////////////////////////
  // read data
  //////////////////////////////////////////////////

  always_ff @(posedge s_axi_aclk)
  begin
    if (!s_axi_aresetn)
      rvalid <= 1'b0;
    else if (rd_valid)
      rvalid <= 1'b1;
    else if (rready)
      rvalid <= 1'b0;
  end

  // word held stable from rd_valid until the next read
  always_ff @(posedge s_axi_aclk)
  begin
    if (rd_valid)
      rdata <= rd_data;
  end

  assign rresp = vram_pkg::resp_okay;

  // frees the request stage on either completed handshake
  assign txn_done = (bvalid && bready) || (rvalid && rready);

  // responses hold, with stable read data, until their ready arrives
  a_b_hold: assert property (
    @(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    bvalid && !bready |=> bvalid
  ) else $error("bvalid dropped before bready");

  a_r_hold: assert property (
    @(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    rvalid && !rready |=> rvalid && $stable(rdata)
  ) else $error("rvalid or rdata changed before rready");

endmodule

// ==== vram_axi_top.sv ====
module vram_axi_top #(
  parameter int axi_addr_width   = 16,
  parameter int vram_addr_bits   = 14,
  parameter int write_resp_delay = 3
) (
  input  logic                      s_axi_aclk,
  input  logic                      s_axi_aresetn,
  // write address
  input  logic [axi_addr_width-1:0] awaddr,
  input  logic                      awvalid,
  output logic                      awready,
  // write data
  input  vram_pkg::axi_data_t       wdata,
  input  vram_pkg::axi_strb_t       wstrb,
  input  logic                      wvalid,
  output logic                      wready,
  // write response
  output vram_pkg::axi_resp_t       bresp,
  output logic                      bvalid,
  input  logic                      bready,
  // read address
  input  logic [axi_addr_width-1:0] araddr,
  input  logic                      arvalid,
  output logic                      arready,
  // read data
  output vram_pkg::axi_data_t       rdata,
  output vram_pkg::axi_resp_t       rresp,
  output logic                      rvalid,
  input  logic                      rready
);

  // ram completions and the handshake-done pulse
  logic                rd_valid;
  vram_pkg::axi_data_t rd_data;
  logic                wr_done;
  logic                txn_done;

  // request stage to ram
  vram_req_if #(.vram_addr_bits(vram_addr_bits)) req_bus ();

  //////////////////////////////////////////////////
  // request -> ram -> response
  //////////////////////////////////////////////////

  axi_request_stage #(
    .axi_addr_width (axi_addr_width),
    .vram_addr_bits (vram_addr_bits)
  ) i_request (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .awaddr        (awaddr),
    .awvalid       (awvalid),
    .awready       (awready),
    .wdata         (wdata),
    .wstrb         (wstrb),
    .wvalid        (wvalid),
    .wready        (wready),
    .araddr        (araddr),
    .arvalid       (arvalid),
    .arready       (arready),
    .txn_done      (txn_done),
    .req           (req_bus.stage)
  );

  vram_bank #(
    .vram_addr_bits (vram_addr_bits)
  ) i_bank (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .req           (req_bus.bank),
    .rd_valid      (rd_valid),
    .rd_data       (rd_data),
    .wr_done       (wr_done)
  );

  axi_response_stage #(
    .write_resp_delay (write_resp_delay)
  ) i_response (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .rd_valid      (rd_valid),
    .rd_data       (rd_data),
    .wr_done       (wr_done),
    .bvalid        (bvalid),
    .bresp         (bresp),
    .bready        (bready),
    .rvalid        (rvalid),
    .rdata         (rdata),
    .rresp         (rresp),
    .rready        (rready),
    .txn_done      (txn_done)
  );

endmodule

// ==== tb_vram_axi.sv ====
module tb_vram_axi;

  localparam int axi_addr_width   = 16;
  localparam int vram_addr_bits   = 14;
  localparam int write_resp_delay = 3;
  // longest any single wait may take, in clock cycles
  localparam int wait_limit = 64;
  // random traffic stays inside eight words from here
  localparam logic [15:0] window_base = 16'h2000;

  logic                      s_axi_aclk = 1'b0;
  logic                      s_axi_aresetn;
  logic [axi_addr_width-1:0] awaddr;
  logic                      awvalid;
  logic                      awready;
  vram_pkg::axi_data_t       wdata;
  vram_pkg::axi_strb_t       wstrb;
  logic                      wvalid;
  logic                      wready;
  vram_pkg::axi_resp_t       bresp;
  logic                      bvalid;
  logic                      bready;
  logic [axi_addr_width-1:0] araddr;
  logic                      arvalid;
  logic                      arready;
  vram_pkg::axi_data_t       rdata;
  vram_pkg::axi_resp_t       rresp;
  logic                      rvalid;
  logic                      rready;

  string test_name;
  logic [31:0] lcg_state = 32'd79671;
  // expected vram contents, keyed by word index
  vram_pkg::axi_data_t model [int];

  vram_axi_top #(
    .axi_addr_width   (axi_addr_width),
    .vram_addr_bits   (vram_addr_bits),
    .write_resp_delay (write_resp_delay)
  ) i_dut (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .awaddr        (awaddr),
    .awvalid       (awvalid),
    .awready       (awready),
    .wdata         (wdata),
    .wstrb         (wstrb),
    .wvalid        (wvalid),
    .wready        (wready),
    .bresp         (bresp),
    .bvalid        (bvalid),
    .bready        (bready),
    .araddr        (araddr),
    .arvalid       (arvalid),
    .arready       (arready),
    .rdata         (rdata),
    .rresp         (rresp),
    .rvalid        (rvalid),
    .rready        (rready)
  );

  always #50 s_axi_aclk = ~s_axi_aclk;

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TB FAILED");
    $fatal(1, "%s", reason);
  endtask

  task automatic check_equal(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
    else
    begin
      $display("** Error %s: %s expected 0x%08h actual 0x%08h",
               test_name, what, expected, actual);
      abort_run("value mismatch");
    end
  endtask

  // one edge, then step past it so outputs are settled and inputs can change
  task automatic tick();
    @(posedge s_axi_aclk);
    #1;
  endtask

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int word_key(input logic [axi_addr_width-1:0] addr);
    return int'(addr[axi_addr_width-1:vram_pkg::addr_lsb]);
  endfunction

  // lanes with a strobe bit come from the new word, the rest keep the old one
  function automatic vram_pkg::axi_data_t merge_lanes(input vram_pkg::axi_data_t old_word,
                                                      input vram_pkg::axi_data_t new_word,
                                                      input vram_pkg::axi_strb_t strb);
    vram_pkg::axi_data_t result;
    result = old_word;
    for (int lane = 0; lane < vram_pkg::strb_width; lane++)
    begin
      if (strb[lane])
      begin
        result[lane*8 +: 8] = new_word[lane*8 +: 8];
      end
    end
    return result;
  endfunction

  //////////////////////////////////////////////////
  // axi driver tasks
  //////////////////////////////////////////////////

  // present aw and w together, count cycles until bvalid shows up
  task automatic write_accept(input logic [15:0] addr, input vram_pkg::axi_data_t data,
                              input vram_pkg::axi_strb_t strb, output int latency);
    int  ready_cycles;
    bit  taken;
    latency      = 0;
    ready_cycles = 0;
    taken        = 1'b0;
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    while (!bvalid)
    begin
      tick();
      latency++;
      // handshake edge has passed
      if (taken)
      begin
        awvalid = 1'b0;
        wvalid  = 1'b0;
      end
      if (awready)
      begin
        ready_cycles++;
        check_equal("wready with awready", 32'd1, 32'(wready));
        taken = 1'b1;
      end
      if (latency > wait_limit)
        abort_run("timeout waiting for bvalid");
    end
    check_equal("awready cycles", 32'd1, 32'(ready_cycles));
  endtask

  task automatic write_finish();
    check_equal("bresp", 32'(vram_pkg::resp_okay), 32'(bresp));
    bready = 1'b1;
    tick();
    bready = 1'b0;
    check_equal("bvalid after bready", 32'd0, 32'(bvalid));
  endtask

  task automatic read_accept(input logic [15:0] addr, output int latency);
    bit taken;
    latency = 0;
    taken   = 1'b0;
    araddr  = addr;
    arvalid = 1'b1;
    while (!rvalid)
    begin
      tick();
      latency++;
      if (taken)
        arvalid = 1'b0;
      if (arready)
        taken = 1'b1;
      if (latency > wait_limit)
        abort_run("timeout waiting for rvalid");
    end
  endtask

  task automatic read_finish(output vram_pkg::axi_data_t data);
    data = rdata;
    check_equal("rresp", 32'(vram_pkg::resp_okay), 32'(rresp));
    rready = 1'b1;
    tick();
    rready = 1'b0;
    check_equal("rvalid after rready", 32'd0, 32'(rvalid));
  endtask

  // complete write from an idle slave, fixed response timing expected
  task automatic write_word(input logic [15:0] addr, input vram_pkg::axi_data_t data,
                            input vram_pkg::axi_strb_t strb);
    int latency;
    write_accept(addr, data, strb, latency);
    check_equal("bvalid latency", write_resp_delay + 2, latency);
    write_finish();
    model[word_key(addr)] = merge_lanes(model[word_key(addr)], data, strb);
  endtask

  task automatic read_word(input logic [15:0] addr);
    int                  latency;
    vram_pkg::axi_data_t got;
    read_accept(addr, latency);
    check_equal("rvalid latency", 32'd3, 32'(latency));
    read_finish(got);
    check_equal("read data", model[word_key(addr)], got);
  endtask

  // response held back, nothing new may be accepted meanwhile
  task automatic hold_and_block(input int cycles);
    logic                b_seen;
    logic                r_seen;
    vram_pkg::axi_data_t r_word;
    b_seen = bvalid;
    r_seen = rvalid;
    r_word = rdata;
    repeat (cycles)
    begin
      tick();
      check_equal("bvalid held", 32'(b_seen), 32'(bvalid));
      check_equal("rvalid held", 32'(r_seen), 32'(rvalid));
      check_equal("rdata held", r_word, rdata);
      check_equal("awready blocked", 32'd0, 32'(awready));
      check_equal("wready blocked", 32'd0, 32'(wready));
      check_equal("arready blocked", 32'd0, 32'(arready));
    end
  endtask

  //////////////////////////////////////////////////
  // protocol assertions
  //////////////////////////////////////////////////

  a_aw_w_together: assert property (
    @(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    awready == wready
  ) else abort_run("awready and wready differ");

  a_b_okay: assert property (
    @(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    bvalid |-> bresp == vram_pkg::resp_okay
  ) else abort_run("bresp is not OKAY");

  a_r_okay: assert property (
    @(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    rvalid |-> rresp == vram_pkg::resp_okay
  ) else abort_run("rresp is not OKAY");

  a_b_hold: assert property (
    @(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    bvalid && !bready |=> bvalid
  ) else abort_run("bvalid dropped before bready");

  a_r_hold: assert property (
    @(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    rvalid && !rready |=> rvalid && $stable(rdata)
  ) else abort_run("rvalid or rdata changed before rready");

  // an open response keeps every address channel closed
  a_no_ready_open: assert property (
    @(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    (bvalid || rvalid) |-> !(awready || arready)
  ) else abort_run("ready raised while a response was pending");

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial
  begin
    vram_pkg::axi_data_t first_word;
    vram_pkg::axi_data_t second_word;
    vram_pkg::axi_data_t got;
    logic [31:0]         pick;
    logic [31:0]         strb_pick;
    logic [15:0]         addr;
    int                  latency;
    s_axi_aresetn = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    test_name = "reset";
    repeat (3) @(posedge s_axi_aclk);
    #1;
    s_axi_aresetn = 1'b1;
    tick();
    check_equal("awready", 32'd0, 32'(awready));
    check_equal("wready", 32'd0, 32'(wready));
    check_equal("arready", 32'd0, 32'(arready));
    check_equal("bvalid", 32'd0, 32'(bvalid));
    check_equal("rvalid", 32'd0, 32'(rvalid));

    // full strobe, then read back
    test_name = "full_word";
    write_word(16'h0040, next_random(), 4'hf);
    read_word(16'h0040);

    // partial strobe over a full word
    test_name = "byte_strobe";
    first_word  = next_random();
    second_word = next_random();
    write_word(16'h0080, first_word, 4'hf);
    write_word(16'h0080, second_word, 4'b0110);
    // lanes 1 and 2 from the second word, lanes 0 and 3 kept from the first
    read_accept(16'h0080, latency);
    check_equal("rvalid latency", 32'd3, 32'(latency));
    read_finish(got);
    check_equal("merged word", {first_word[31:24], second_word[23:8], first_word[7:0]},
                got);

    // bready low with a read waiting behind it
    test_name = "back_pressure";
    first_word = next_random();
    write_accept(16'h00c0, first_word, 4'hf, latency);
    model[word_key(16'h00c0)] = first_word;
    araddr  = 16'h0040;
    arvalid = 1'b1;
    hold_and_block(5);
    write_finish();
    // rready low with a write waiting behind it
    read_accept(16'h0040, latency);
    second_word = next_random();
    awaddr  = 16'h00c4;
    wdata   = second_word;
    wstrb   = 4'hf;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    hold_and_block(5);
    read_finish(got);
    check_equal("held read data", model[word_key(16'h0040)], got);
    write_accept(16'h00c4, second_word, 4'hf, latency);
    write_finish();
    model[word_key(16'h00c4)] = second_word;
    read_word(16'h00c4);
    read_word(16'h00c0);

    // mixed traffic over eight words, reads only where something was written
    test_name = "random_traffic";
    for (int op = 0; op < 40; op++)
    begin
      pick = next_random();
      addr = window_base + {11'd0, pick[12:10], 2'b00};
      if (pick[20] && model.exists(word_key(addr)))
      begin
        read_word(addr);
      end
      else
      begin
        strb_pick = next_random();
        // first write to a word sets every lane so the model has no unknowns
        write_word(addr, next_random(),
                   model.exists(word_key(addr)) ? strb_pick[7:4] : 4'hf);
      end
    end

    $display("TB PASSED");
    $finish;
  end

endmodule

// ==== tb.f ====
vram_pkg.sv
vram_req_if.sv
axi_request_stage.sv
vram_bank.sv
axi_response_stage.sv
vram_axi_top.sv
tb_vram_axi.sv

// ==== Makefile ====
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_vram_axi
FILELIST   = tb.f
OBJ_DIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
